//--- source/coproc_pkg.sv
package coproc_pkg;

  localparam int XLEN       = 32;               // data and address width, one word
  localparam int FIELD_W    = 5;                // bit index width
  localparam int WORD_BYTES = 4;                // byte stride between lower and higher word
  localparam int WORD_OFF_W = XLEN - FIELD_W;   // word offset part of rs1

  // custom opcode space of the core
  typedef enum logic [6:0] {
    OPCODE_CFG  = 7'b000_1011,  // custom-0
    OPCODE_RMLD = 7'b010_1011,  // custom-1
    OPCODE_RMST = 7'b101_1011   // custom-2
  } coproc_opcode_e;

  // bit 2 set marks the configuration codes
  typedef enum logic [2:0] {
    RMXR   = 3'b000,  // store zeros
    RMXS   = 3'b001,  // store ones
    RMCS   = 3'b010,  // store from shadow register
    CDSRM  = 3'b100,  // custom data register, retires without effect
    CASRM  = 3'b101,  // store base from rs1
    CALRM  = 3'b110,  // load base from rs2
    CASLRM = 3'b111   // both bases
  } coproc_funct3_e;

  typedef enum logic [2:0] {
    IDLE,
    CFG,
    MEM_RD1,
    MEM_RD2,
    UPDATE,
    MEM_WR1,
    MEM_WR2,
    RETIRE
  } coproc_state_e;

  typedef struct packed {
    logic [WORD_OFF_W-1:0] word_off;  // in words from the base
    logic [FIELD_W-1:0]    bit_idx;   // first bit of the field
  } bit_pos_t;

  // rs1 is an address for configuration and a bit position for load/store
  typedef union packed {
    logic [XLEN-1:0] raw;
    bit_pos_t        pos;
  } bit_pos_u;

endpackage

//--- source/bf_ctrl_if.sv
`timescale 1ns/100ps

interface bf_ctrl_if import coproc_pkg::*; ();

  logic                 capture_mask;   // build the field mask
  logic                 load_lo;        // lower word valid on rdata
  logic                 load_hi;        // higher word valid on rdata
  logic                 commit_shadow;  // copy pending field into shadow
  logic                 is_load;
  coproc_funct3_e       src_sel;        // store source
  logic [FIELD_W-1:0]   bit_idx;
  logic [FIELD_W:0]     count;          // 1 to 32
  logic [XLEN-1:0]      rdata;
  logic [XLEN-1:0]      wdata_lo;
  logic [XLEN-1:0]      wdata_hi;

  modport ctrl (
    output capture_mask, load_lo, load_hi, commit_shadow, is_load, src_sel,
    input  wdata_lo, wdata_hi
  );

  modport dp (
    input  capture_mask, load_lo, load_hi, commit_shadow, is_load, src_sel,
    input  bit_idx, count, rdata,
    output wdata_lo, wdata_hi
  );

endinterface

//--- source/rshifter32.sv
`timescale 1ns/100ps

module rshifter32 (
  input  logic [31:0] d,
  input  logic [4:0]  shift_amount,
  input  logic        rotate_en,
  output logic [31:0] q
);

  logic [63:0] doubled;   // word next to itself, low half is the rotation
  logic [31:0] shifted;

  assign doubled = {d, d} >> shift_amount;
  assign shifted = d >> shift_amount;

  assign q = rotate_en ? doubled[31:0] : shifted;

endmodule

//--- source/coproc_issue.sv
`timescale 1ns/100ps

module coproc_issue import coproc_pkg::*; #(
  parameter int ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_valid,
  input  logic                issue_ready,
  input  logic [XLEN-1:0]     issue_instr,
  input  logic [XLEN-1:0]     issue_rs1,
  input  logic [XLEN-1:0]     issue_rs2,
  input  logic [ID_WIDTH-1:0] issue_id,
  output logic                issue_accept,
  input  logic                cfg_write,
  output coproc_opcode_e      opcode,
  output coproc_funct3_e      funct3,
  output logic [FIELD_W-1:0]  bit_idx,
  output logic [FIELD_W:0]    count,
  output logic [XLEN-1:0]     ld_addr,
  output logic [XLEN-1:0]     st_addr,
  output logic [ID_WIDTH-1:0] id
);

  logic [XLEN-1:0]     instr_q;
  bit_pos_u            rs1_q;
  logic [XLEN-1:0]     rs2_q;
  logic [ID_WIDTH-1:0] id_q;
  logic [XLEN-1:0]     bld_q;     // load base
  logic [XLEN-1:0]     bst_q;     // store base
  logic [XLEN-1:0]     byte_off;
  logic                issue_take;

  // refused opcodes never get captured
  assign issue_accept = issue_instr[6:0] inside {OPCODE_CFG, OPCODE_RMLD, OPCODE_RMST};
  assign issue_take   = issue_valid & issue_ready & issue_accept;

  always_ff @(posedge clk_i) begin
    if (issue_take) begin
      instr_q   <= issue_instr;
      rs1_q.raw <= issue_rs1;
      rs2_q     <= issue_rs2;
      id_q      <= issue_id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bld_q <= '0;
      bst_q <= '0;
    end else if (cfg_write) begin
      case (funct3)
        CASRM:   bst_q <= rs1_q.raw;
        CALRM:   bld_q <= rs2_q;
        CASLRM: begin
          bst_q <= rs1_q.raw;
          bld_q <= rs2_q;
        end
        default: ;  // CDSRM has nothing left to set
      endcase
    end
  end

  assign opcode  = coproc_opcode_e'(instr_q[6:0]);
  assign funct3  = coproc_funct3_e'(instr_q[14:12]);
  assign bit_idx = rs1_q.pos.bit_idx;
  assign count   = (FIELD_W+1)'(rs2_q[FIELD_W-1:0]) + (FIELD_W+1)'(1);   // 1 to 32
  assign id      = id_q;

  assign byte_off = XLEN'(rs1_q.pos.word_off) * XLEN'(WORD_BYTES);
  assign ld_addr  = bld_q + byte_off;
  assign st_addr  = bst_q + byte_off;

endmodule

//--- source/coproc_fsm.sv
`timescale 1ns/100ps

module coproc_fsm import coproc_pkg::*; #(
  parameter int ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  coproc_opcode_e      opcode,
  input  coproc_funct3_e      funct3,
  input  logic [XLEN-1:0]     ld_addr,
  input  logic [XLEN-1:0]     st_addr,
  input  logic [ID_WIDTH-1:0] id,
  input  logic                issue_valid,
  input  logic                issue_accept,
  output logic                issue_ready,
  input  logic                commit_valid,
  output logic                mem_valid,
  output logic [XLEN-1:0]     mem_addr,
  output logic                mem_we,
  output logic [XLEN-1:0]     mem_wdata,
  input  logic                mem_result_valid,
  output logic                result_valid,
  output logic [ID_WIDTH-1:0] result_id,
  input  logic                result_ready,
  output logic                cfg_write,
  bf_ctrl_if.ctrl             ctrl
);

  coproc_state_e   state_q;
  coproc_state_e   state_n;
  logic            issued_q;      // captured operands valid this cycle
  logic            commit_seen_q;
  logic            commit_ok;
  logic            is_load;
  logic [XLEN-1:0] base_addr;

  assign is_load   = (opcode == OPCODE_RMLD);
  assign commit_ok = commit_seen_q | commit_valid;

  // one instruction in flight, taken only while idle
  assign issue_ready = (state_q == IDLE) & ~issued_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      issued_q      <= 1'b0;
      commit_seen_q <= 1'b0;
    end else begin
      state_q  <= state_n;
      issued_q <= issue_valid & issue_ready & issue_accept;
      if (result_valid && result_ready) begin
        commit_seen_q <= 1'b0;              // cleared once the result is taken
      end else if (commit_valid) begin
        commit_seen_q <= 1'b1;
      end
    end
  end

  always_comb begin
    state_n = state_q;
    case (state_q)
      IDLE: begin
        if (issued_q) begin
          state_n = (opcode == OPCODE_CFG) ? CFG : MEM_RD1;
        end
      end
      CFG: begin
        if (commit_ok) begin
          state_n = RETIRE;
        end
      end
      MEM_RD1: begin
        if (mem_result_valid) begin
          state_n = MEM_RD2;
        end
      end
      MEM_RD2: begin
        if (mem_result_valid) begin
          state_n = UPDATE;
        end
      end
      UPDATE: begin
        // nothing visible changes before commit
        if (commit_ok) begin
          state_n = is_load ? RETIRE : MEM_WR1;
        end
      end
      MEM_WR1: begin
        if (mem_result_valid) begin
          state_n = MEM_WR2;
        end
      end
      MEM_WR2: begin
        if (mem_result_valid) begin
          state_n = RETIRE;
        end
      end
      RETIRE: begin
        if (result_ready) begin
          state_n = IDLE;
        end
      end
      default: state_n = IDLE;
    endcase
  end

  assign cfg_write = (state_q == CFG) & commit_ok;

  // datapath strobes
  assign ctrl.capture_mask  = (state_q == IDLE) & issued_q & (opcode != OPCODE_CFG);
  assign ctrl.load_lo       = (state_q == MEM_RD1) & mem_result_valid;
  assign ctrl.load_hi       = (state_q == MEM_RD2) & mem_result_valid;
  assign ctrl.commit_shadow = (state_q == UPDATE) & commit_ok & is_load;
  assign ctrl.is_load       = is_load;
  assign ctrl.src_sel       = funct3;

  assign base_addr = is_load ? ld_addr : st_addr;

  assign mem_valid = state_q inside {MEM_RD1, MEM_RD2, MEM_WR1, MEM_WR2};
  assign mem_we    = state_q inside {MEM_WR1, MEM_WR2};
  assign mem_wdata = (state_q == MEM_WR2) ? ctrl.wdata_hi : ctrl.wdata_lo;

  always_comb begin
    if (state_q inside {MEM_RD2, MEM_WR2}) begin
      mem_addr = base_addr + XLEN'(WORD_BYTES);   // higher word
    end else begin
      mem_addr = base_addr;
    end
  end

  assign result_valid = (state_q == RETIRE);
  assign result_id    = id;

endmodule

//--- source/bitfield_datapath.sv
`timescale 1ns/100ps

module bitfield_datapath import coproc_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  bf_ctrl_if.dp dp
);

  logic [XLEN-1:0]    unary;       // count ones at bit 0
  logic [XLEN-1:0]    lo_sel;      // bits at or above bit_idx
  logic [FIELD_W-1:0] neg_idx;
  logic [XLEN-1:0]    lo_mask_q;   // field bits in the lower word
  logic [XLEN-1:0]    hi_mask_q;   // field bits in the higher word
  logic [XLEN-1:0]    word_lo_q;
  logic [XLEN-1:0]    word_hi_q;
  logic [XLEN-1:0]    shadow_q;
  logic [XLEN-1:0]    src_word;
  logic [XLEN-1:0]    sh_d;
  logic [FIELD_W-1:0] sh_amt;
  logic               sh_rot;
  logic [XLEN-1:0]    sh_q;

  // count of 32 is the only value with the top bit set
  assign unary   = dp.count[FIELD_W] ? '1
                 : (XLEN'(1) << dp.count[FIELD_W-1:0]) - XLEN'(1);
  assign neg_idx = FIELD_W'(0) - dp.bit_idx;   // right rotate by this is a left rotate
  assign lo_sel  = {XLEN{1'b1}} << dp.bit_idx;

  // one shifter, shared by the strobes; idle it places the shadow for stores
  always_comb begin
    if (dp.capture_mask) begin
      sh_d   = unary;
      sh_amt = neg_idx;
      sh_rot = 1'b1;
    end else if (dp.load_lo) begin
      sh_d   = dp.rdata & lo_mask_q;
      sh_amt = dp.bit_idx;
      sh_rot = 1'b0;
    end else if (dp.load_hi) begin
      sh_d   = dp.rdata & hi_mask_q;   // wraps the high part above the low part
      sh_amt = dp.bit_idx;
      sh_rot = 1'b1;
    end else begin
      sh_d   = shadow_q;
      sh_amt = neg_idx;
      sh_rot = 1'b1;
    end
  end

  rshifter32 u_rshifter32 (
    .d            (sh_d),
    .shift_amount (sh_amt),
    .rotate_en    (sh_rot),
    .q            (sh_q)
  );

  // rotated unary splits at bit_idx, also right for the full 32-bit field
  always_ff @(posedge clk_i) begin
    if (dp.capture_mask) begin
      lo_mask_q <= sh_q & lo_sel;
      hi_mask_q <= sh_q & ~lo_sel;
    end
  end

  // a load keeps the two shifted field parts, a store the raw words
  always_ff @(posedge clk_i) begin
    if (dp.load_lo) begin
      word_lo_q <= dp.is_load ? sh_q : dp.rdata;
    end
    if (dp.load_hi) begin
      word_hi_q <= dp.is_load ? sh_q : dp.rdata;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      shadow_q <= '0;
    end else if (dp.commit_shadow) begin
      shadow_q <= word_lo_q | word_hi_q;   // pending field, right aligned
    end
  end

  always_comb begin
    case (dp.src_sel)
      RMXR:    src_word = '0;
      RMXS:    src_word = '1;
      RMCS:    src_word = sh_q;    // shadow rotated up to bit_idx
      default: src_word = '0;
    endcase
  end

  assign dp.wdata_lo = (word_lo_q & ~lo_mask_q) | (src_word & lo_mask_q);
  assign dp.wdata_hi = (word_hi_q & ~hi_mask_q) | (src_word & hi_mask_q);

endmodule

//--- source/coproc_top.sv
`timescale 1ns/100ps

module coproc_top import coproc_pkg::*; #(
  parameter int ID_WIDTH = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_valid,
  output logic                issue_ready,
  input  logic [XLEN-1:0]     issue_instr,
  input  logic [XLEN-1:0]     issue_rs1,
  input  logic [XLEN-1:0]     issue_rs2,
  input  logic [ID_WIDTH-1:0] issue_id,
  output logic                issue_accept,
  input  logic                commit_valid,
  output logic                mem_valid,
  output logic [XLEN-1:0]     mem_addr,
  output logic                mem_we,
  output logic [XLEN-1:0]     mem_wdata,
  input  logic [XLEN-1:0]     mem_rdata,
  input  logic                mem_result_valid,
  output logic                result_valid,
  output logic [ID_WIDTH-1:0] result_id,
  input  logic                result_ready
);

  coproc_opcode_e      opcode;
  coproc_funct3_e      funct3;
  logic [FIELD_W-1:0]  bit_idx;
  logic [FIELD_W:0]    count;
  logic [XLEN-1:0]     ld_addr;
  logic [XLEN-1:0]     st_addr;
  logic [ID_WIDTH-1:0] id;
  logic                cfg_write;

  bf_ctrl_if u_bf_if ();

  assign u_bf_if.bit_idx = bit_idx;
  assign u_bf_if.count   = count;
  assign u_bf_if.rdata   = mem_rdata;

  coproc_issue #(
    .ID_WIDTH (ID_WIDTH)
  ) u_issue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue_instr  (issue_instr),
    .issue_rs1    (issue_rs1),
    .issue_rs2    (issue_rs2),
    .issue_id     (issue_id),
    .issue_accept (issue_accept),
    .cfg_write    (cfg_write),
    .opcode       (opcode),
    .funct3       (funct3),
    .bit_idx      (bit_idx),
    .count        (count),
    .ld_addr      (ld_addr),
    .st_addr      (st_addr),
    .id           (id)
  );

  coproc_fsm #(
    .ID_WIDTH (ID_WIDTH)
  ) u_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .opcode           (opcode),
    .funct3           (funct3),
    .ld_addr          (ld_addr),
    .st_addr          (st_addr),
    .id               (id),
    .issue_valid      (issue_valid),
    .issue_accept     (issue_accept),
    .issue_ready      (issue_ready),
    .commit_valid     (commit_valid),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_we           (mem_we),
    .mem_wdata        (mem_wdata),
    .mem_result_valid (mem_result_valid),
    .result_valid     (result_valid),
    .result_id        (result_id),
    .result_ready     (result_ready),
    .cfg_write        (cfg_write),
    .ctrl             (u_bf_if.ctrl)
  );

  bitfield_datapath u_datapath (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .dp     (u_bf_if.dp)
  );

endmodule

//--- tb/coproc_tb.sv
`timescale 1ns/100ps

module coproc_tb;

  localparam int HALF_PERIOD = 20;
  localparam int TIMEOUT     = 200;   // cycles allowed per wait

  logic        clk_i = 1'b0;
  logic        rst_ni = 1'b0;
  logic        issue_valid;
  logic        issue_ready;
  logic [31:0] issue_instr;
  logic [31:0] issue_rs1;
  logic [31:0] issue_rs2;
  logic [3:0]  issue_id;
  logic        issue_accept;
  logic        commit_valid;
  logic        mem_valid;
  logic [31:0] mem_addr;
  logic        mem_we;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata = '0;
  logic        mem_result_valid = 1'b0;
  logic        result_valid;
  logic [3:0]  result_id;
  logic        result_ready;

  logic [31:0] mem_model [logic [31:0]];
  int          seed = 53;
  int          errors = 0;
  int          checks = 0;
  int          req_wait = -1;   // cycles left before the memory answers
  bit          committed = 1'b0;
  bit          aborted = 1'b0;

  coproc_top #(
    .ID_WIDTH (4)
  ) u_coproc_top (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .issue_valid      (issue_valid),
    .issue_ready      (issue_ready),
    .issue_instr      (issue_instr),
    .issue_rs1        (issue_rs1),
    .issue_rs2        (issue_rs2),
    .issue_id         (issue_id),
    .issue_accept     (issue_accept),
    .commit_valid     (commit_valid),
    .mem_valid        (mem_valid),
    .mem_addr         (mem_addr),
    .mem_we           (mem_we),
    .mem_wdata        (mem_wdata),
    .mem_rdata        (mem_rdata),
    .mem_result_valid (mem_result_valid),
    .result_valid     (result_valid),
    .result_id        (result_id),
    .result_ready     (result_ready)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  function automatic logic [31:0] mem_read(input logic [31:0] addr);
    if (mem_model.exists(addr)) begin
      return mem_model[addr];
    end
    return addr ^ 32'h5a5a_a5a5;   // fill for words never written
  endfunction

  // memory answers each request after 0 to 3 cycles
  always @(negedge clk_i) begin
    if (mem_result_valid || !mem_valid) begin
      mem_result_valid <= 1'b0;
    end else begin
      if (req_wait < 0) begin
        req_wait = {$random(seed)} % 4;
      end
      if (req_wait == 0) begin
        if (mem_we) begin
          if (!committed) begin
            $display("memory write to %h happened before commit", mem_addr);
            errors++;
          end
          mem_model[mem_addr] = mem_wdata;
        end else begin
          mem_rdata <= mem_read(mem_addr);
        end
        mem_result_valid <= 1'b1;
      end
      req_wait--;
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_bad_line(input string line);
    $display("a line of the test file could not be parsed: %s", line);
    errors++;
  endtask

  task automatic wait_ready(input string name);
    int t;
    t = 0;
    while (!issue_ready && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (!issue_ready) begin
      $display("%s: the coprocessor never became ready to take an instruction", name);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic wait_result(input string name);
    int t;
    t = 0;
    while (!result_valid && t < TIMEOUT) begin
      @(negedge clk_i);
      t++;
    end
    if (!result_valid) begin
      $display("%s: no result came back from the coprocessor", name);
      errors++;
      aborted = 1'b1;
    end
  endtask

  // issue one instruction, commit it after delay cycles, take its result
  task automatic run_op(input string name, input logic [6:0] opc, input logic [2:0] f3,
                        input logic [31:0] rs1, input logic [31:0] rs2,
                        input logic [3:0] id, input int delay, input int acc);
    int hold;
    wait_ready(name);
    if (aborted) return;
    issue_valid  = 1'b1;
    issue_instr  = {17'b0, f3, 5'b0, opc};
    issue_rs1    = rs1;
    issue_rs2    = rs2;
    issue_id     = id;
    committed    = (delay == 0) && (acc != 0);
    commit_valid = committed;
    @(negedge clk_i);
    check_value({name, " accept"}, 32'(acc), 32'(issue_accept));
    issue_valid  = 1'b0;
    commit_valid = 1'b0;
    if (acc == 0) begin
      repeat (3) begin
        @(negedge clk_i);
        check_value({name, " no request"}, 32'd0, 32'(mem_valid));
      end
      return;
    end
    if (delay > 0) begin
      repeat (delay - 1) @(negedge clk_i);
      committed    = 1'b1;
      commit_valid = 1'b1;
      @(negedge clk_i);
      commit_valid = 1'b0;
    end
    wait_result(name);
    if (aborted) return;
    check_value({name, " id"}, 32'(id), 32'(result_id));
    hold = {$random(seed)} % 3;   // result_ready back-pressure
    repeat (hold) @(negedge clk_i);
    result_ready = 1'b1;
    @(negedge clk_i);
    result_ready = 1'b0;
  endtask

  initial begin
    int          fd;
    int          n;
    string       line;
    string       kind;
    string       name;
    logic [31:0] addr;
    logic [31:0] data;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [3:0]  id;
    int          delay;
    int          acc;

    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_id     = '0;
    commit_valid = 1'b0;
    result_ready = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("reset issue_ready", 32'd1, 32'(issue_ready));
    check_value("reset mem_valid", 32'd0, 32'(mem_valid));
    check_value("reset result_valid", 32'd0, 32'(result_valid));

    fd = $fopen("tb/coproc_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/coproc_tests.txt");
      errors++;
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        kind = "";
        n = $sscanf(line, "%s", kind);
        if (kind == "mem") begin
          n = $sscanf(line, "%s %h %h", kind, addr, data);
          if (n == 3) begin
            mem_model[addr] = data;
          end else begin
            report_bad_line(line);
          end
        end else if (kind == "op") begin
          n = $sscanf(line, "%s %s %h %h %h %h %h %d %d",
                      kind, name, opc, f3, rs1, rs2, id, delay, acc);
          if (n == 9) begin
            run_op(name, opc, f3, rs1, rs2, id, delay, acc);
          end else begin
            report_bad_line(line);
          end
        end else if (kind == "expect") begin
          n = $sscanf(line, "%s %s %h %h", kind, name, addr, data);
          if (n == 4) begin
            check_value(name, data, mem_read(addr));
          end else begin
            report_bad_line(line);
          end
        end
      end
      $fclose(fd);
    end

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- tb/coproc_tests.txt
# mem    <addr> <word>
# op     <name> <opcode> <funct3> <rs1> <rs2> <id> <commit delay> <accept>  expect <name> <addr> <word>
mem 00001000 cafebabe
mem 00001004 01234567
mem 00001008 aabbccdd
mem 0000100c 11223344
mem 00002008 12345678
mem 0000200c 9abcdef0
mem 00002010 ffffffff
mem 00002014 ffffffff
mem 00002018 11111111
mem 0000201c 22222222
mem 00002020 00000000
mem 00002024 ffffffff
op bad_opcode 7f 0 00000000 00000000 1 0 0
op cfg_bases 0b 7 00002000 00001000 3 0 1
op set_ones 5b 1 0000005c 00000007 4 1 1
expect set_ones_lo 00002008 f2345678
expect set_ones_hi 0000200c 9abcdeff
op clear_late 5b 0 00000094 0000000f 5 6 1
expect clear_late_lo 00002010 000fffff
expect clear_late_hi 00002014 fffffff0
op load_24 2b 0 0000000c 00000017 6 0 1
expect load_untouched 00001000 cafebabe
op copy_24 5b 2 000000d4 00000017 7 5 1
expect copy_24_lo 00002018 feb11111
expect copy_24_hi 0000201c 222227ca
op load_32 2b 0 00000050 0000001f 8 4 1
op copy_32 5b 2 00000104 0000001f 9 0 1
expect copy_32_lo 00002020 344aabb0
expect copy_32_hi 00002024 fffffff3

//--- filelist.f
source/coproc_pkg.sv
source/bf_ctrl_if.sv
source/rshifter32.sv
source/coproc_issue.sv
source/coproc_fsm.sv
source/bitfield_datapath.sv
source/coproc_top.sv
tb/coproc_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module coproc_tb -f filelist.f -o coproc_sim
./obj_dir/coproc_sim > sim.log
cat sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
